//--- files.f
source/cu_cache_cfg_pkg.sv
source/mem_packet_pkg.sv
source/sync_fifo.sv
source/request_path.sv
source/cu_cache_control.sv
source/response_path.sv
source/cu_cache_top.sv
testbench/cu_cache_props.sv
testbench/tb_cu_cache.sv

//--- Makefile
# Verilator build and run for the memory front end testbench

SRCS := $(shell cat files.f)
BIN  := obj_dir/Vtb_cu_cache

.PHONY: all run clean

all: run

$(BIN): files.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_cu_cache -f files.f

run: $(BIN)
	@out="$$(./$(BIN))"; status=$$?; echo "$$out"; \
	echo "$$out" | grep -qx 'Test OK' && [ $$status -eq 0 ]

clean:
	rm -rf obj_dir

//--- testbench/tb_cu_cache.sv
// --------------------------------------------------------------------------
// Testbench for the compute-unit memory front end
// Backend memory model, credit-driven requester and in-order reply checks
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_cu_cache;

  localparam int N_STALL    = 40;
  localparam int N_REQ      = 48 + N_STALL;
  localparam int REQ_CREDIT = 16;
  localparam logic [15:0] BASE = 16'h1200;

  logic ap_clk, areset_control, desc_valid_i, req_valid_i, req_cmd_i, req_credit_o;
  logic [15:0] desc_base_i, req_addr_i, resp_addr_o, mem_addr_o;
  mem_packet_pkg::mem_req_body_u req_body_i;
  logic resp_credit_i, resp_valid_o, resp_cmd_o, mem_valid_o;
  logic [7:0] resp_tag_o;
  logic [31:0] resp_data_o, mem_wdata_o, mem_rdata_i;
  logic [3:0] mem_wstrb_o;
  logic mem_ready_i, mem_rvalid_i, mem_wtb_empty_i, done_o;

  logic [31:0] mem_model [65536];
  logic [31:0] ref_mem [65536];
  logic [56:0] exp_q [$];
  integer seed = 32'h2f11993c;
  int sent, returned, granted, received, cyc, last_send, rd_wait;
  int stall_base, quiet_cyc;
  logic grant_en, wtb_rand;

  cu_cache_top i_cu_cache_top (.*);

  initial begin
    ap_clk = 1'b0;
    forever #5 ap_clk = ~ap_clk;
  end

  // Fill word depends on every address bit
  function automatic logic [31:0] fill_word(input logic [15:0] a);
    return {a, a ^ 16'ha5c3};
  endfunction

  // Byte lanes replaced where the strobe is set
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] new_w,
                                              input logic [3:0] strb);
    logic [31:0] r;
    r = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) r[8*b +: 8] = new_w[8*b +: 8];
    end
    return r;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("ERROR @%0t: %s", $time, msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  // Requester, spends one credit per request
  task automatic send_req(input logic cmd, input logic [15:0] addr, input logic [31:0] data,
                          input logic [3:0] strb, input logic [7:0] tag);
    logic [15:0] a;
    a = addr + BASE;
    while (sent - returned >= REQ_CREDIT) @(negedge ap_clk);
    req_valid_i = 1'b1;
    req_cmd_i   = cmd;
    req_addr_i  = addr;
    if (cmd == mem_packet_pkg::CMD_WRITE) begin
      req_body_i.wr = {strb, data};
      ref_mem[a] = merge_bytes(ref_mem[a], data, strb);
      exp_q.push_back({cmd, a, 8'h00, 32'h0});
    end else begin
      req_body_i.rd = {28'h0, tag};
      exp_q.push_back({cmd, a, tag, ref_mem[a]});
    end
    sent++;
    last_send = cyc;
    @(negedge ap_clk);
    req_valid_i = 1'b0;
  endtask

  // Backend memory, random read latency and write buffer state
  always @(negedge ap_clk) begin
    mem_wtb_empty_i <= wtb_rand ? 1'($random(seed)) : 1'b1;
    if (mem_rvalid_i) begin
      mem_rvalid_i <= 1'b0;
    end else if (mem_valid_o && mem_wstrb_o == 4'h0) begin
      if (rd_wait == 0) rd_wait = 1 + int'($unsigned($random(seed)) % 4);
      rd_wait--;
      if (rd_wait == 0) begin
        mem_rvalid_i <= 1'b1;
        mem_rdata_i  <= mem_model[mem_addr_o];
      end
    end else if (mem_valid_o) begin
      mem_model[mem_addr_o] <= merge_bytes(mem_model[mem_addr_o], mem_wdata_o, mem_wstrb_o);
    end
  end

  // Response credits, at most 8 outstanding
  always @(negedge ap_clk) begin
    resp_credit_i <= grant_en && (granted - received < 8);
    if (grant_en && (granted - received < 8)) granted++;
  end

  // ------------------------------------------------------------------------
  // Reply checks against the reference queue
  // ------------------------------------------------------------------------
  always @(negedge ap_clk) begin
    logic [56:0] got;
    logic [56:0] exp;
    cyc++;
    if (req_credit_o) returned++;
    if (resp_valid_o) begin
      received++;
      got = {resp_cmd_o, resp_addr_o, resp_tag_o, resp_data_o};
      assert (exp_q.size() > 0) else stop_on_error("response with none outstanding");
      exp = exp_q.pop_front();
      assert (got == exp) else
        stop_on_error($sformatf("response %h, expected %h", got, exp));
    end
    // Done must stay low while a reply is owed
    if (done_o && cyc - last_send > 4) begin
      assert (exp_q.size() == 0) else stop_on_error("done_o high with responses owed");
    end
  end

  initial begin
    repeat (N_REQ * 200) @(posedge ap_clk);
    $display("Timeout: the run did not complete in the allowed time");
    $display("Test FAILED");
    $fatal(1);
  end

  initial begin
    areset_control = 1'b1;
    {desc_valid_i, req_valid_i, req_cmd_i, resp_credit_i, mem_rvalid_i} = '0;
    desc_base_i = '0;
    req_addr_i  = '0;
    req_body_i  = '0;
    mem_rdata_i = '0;
    mem_ready_i = 1'b1;
    mem_wtb_empty_i = 1'b1;
    {sent, returned, granted, received, cyc, last_send, rd_wait} = '0;
    stall_base = 0;
    quiet_cyc  = 0;
    grant_en = 1'b0;
    wtb_rand = 1'b1;
    for (int i = 0; i < 65536; i++) begin
      mem_model[i] = fill_word(16'(i));
      ref_mem[i]   = fill_word(16'(i));
    end
    repeat (3) @(negedge ap_clk);
    areset_control = 1'b0;
    // Quiet outputs before any descriptor
    repeat (5) begin
      @(negedge ap_clk);
      assert (!req_credit_o && !mem_valid_o && !resp_valid_o) else
        stop_on_error("output active before descriptor and request");
    end
    desc_valid_i = 1'b1;
    desc_base_i  = BASE;
    @(negedge ap_clk);
    desc_valid_i = 1'b0;
    grant_en = 1'b1;
    // Writes then reads back, then a random mix
    for (int i = 0; i < 8; i++) begin
      send_req(mem_packet_pkg::CMD_WRITE, 16'(i), $random(seed), 4'(i + 1), 8'h0);
    end
    for (int i = 0; i < 8; i++) send_req(mem_packet_pkg::CMD_READ, 16'(i), 0, 0, 8'(8'h40 + i));
    for (int i = 0; i < 32; i++) begin
      send_req(1'($random(seed)), 16'($random(seed) & 15), $random(seed),
               4'(($random(seed) & 14) | 1), 8'($random(seed)));
    end
    while (exp_q.size() != 0) @(negedge ap_clk);
    // Withheld credits stall the requester
    grant_en   = 1'b0;
    stall_base = sent;
    fork
      for (int i = 0; i < N_STALL; i++) begin
        send_req(mem_packet_pkg::CMD_READ, 16'(i & 15), 0, 0, 8'(i));
      end
    join_none
    // Stall has settled once no credit comes back for a while
    while (quiet_cyc < 40) begin
      @(negedge ap_clk);
      quiet_cyc = req_credit_o ? 0 : quiet_cyc + 1;
    end
    assert (sent - stall_base < N_STALL && sent - returned == REQ_CREDIT) else
      stop_on_error("requester was not stalled without response credits");
    grant_en = 1'b1;
    wait fork;
    while (exp_q.size() != 0) @(negedge ap_clk);
    wtb_rand = 1'b0;
    while (!done_o) @(negedge ap_clk);
    $display("Test OK");
    $finish;
  end

endmodule

//--- testbench/cu_cache_props.sv
// --------------------------------------------------------------------------
// Protocol and credit properties of the front end, bound to the top level
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module cu_cache_props (
  input logic                              ap_clk,
  input logic                              areset_control,
  input logic                              req_credit_o,
  input logic                              resp_credit_i,
  input logic                              resp_valid_o,
  input logic                              resp_cmd_o,
  input logic [mem_packet_pkg::TAG_W-1:0]  resp_tag_o,
  input logic [mem_packet_pkg::DATA_W-1:0] resp_data_o,
  input logic                              mem_valid_o,
  input logic [mem_packet_pkg::STRB_W-1:0] mem_wstrb_o,
  input logic                              mem_rvalid_i,
  input logic                              head_cmd_i,
  input logic                              done_o
);

  // Credits granted and not yet spent by a response
  logic [7:0] credit_cnt;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      credit_cnt <= '0;
    end else begin
      credit_cnt <= credit_cnt + 8'(resp_credit_i) - 8'(resp_valid_o);
    end
  end

  // Quiet outputs out of reset
  a_reset_quiet: assert property (@(posedge ap_clk) $past(areset_control) |->
    !req_credit_o && !mem_valid_o && !resp_valid_o && !done_o) else $error("busy after reset");

  // ------------------------------------------------------------------------
  // Backend port
  // ------------------------------------------------------------------------
  a_read_hold: assert property (@(posedge ap_clk) disable iff (areset_control)
    (mem_valid_o && mem_wstrb_o == '0) |=> (mem_valid_o || mem_rvalid_i))
    else $error("read dropped before rvalid");

  a_write_pulse: assert property (@(posedge ap_clk) disable iff (areset_control)
    (mem_valid_o && mem_wstrb_o != '0) |=> !mem_valid_o)
    else $error("write held longer than one cycle");

  // Read in progress, taken from the command at the queue head
  a_read_strb: assert property (@(posedge ap_clk) disable iff (areset_control)
    ((mem_valid_o || mem_rvalid_i) && head_cmd_i == mem_packet_pkg::CMD_READ) |->
    mem_wstrb_o == '0) else $error("strobes set on a read");

  // ------------------------------------------------------------------------
  // Response side
  // ------------------------------------------------------------------------
  a_credit: assert property (@(posedge ap_clk) disable iff (areset_control)
    resp_valid_o |-> credit_cnt != '0) else $error("response without credit");

  a_write_resp: assert property (@(posedge ap_clk) disable iff (areset_control)
    (resp_valid_o && resp_cmd_o == mem_packet_pkg::CMD_WRITE) |->
    (resp_tag_o == '0 && resp_data_o == '0)) else $error("write reply not zero");

endmodule

bind cu_cache_top cu_cache_props i_cu_cache_props (.*, .head_cmd_i (head_cmd));

//--- source/cu_cache_top.sv
// --------------------------------------------------------------------------
// Compute-unit memory front end
// Request path, command control and response path around a word backend
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module cu_cache_top (
  input  logic                                ap_clk,
  input  logic                                areset_control,
  input  logic                                desc_valid_i,
  input  logic [mem_packet_pkg::ADDR_W-1:0]   desc_base_i,
  input  logic                                req_valid_i,
  input  logic                                req_cmd_i,
  input  logic [mem_packet_pkg::ADDR_W-1:0]   req_addr_i,
  input  mem_packet_pkg::mem_req_body_u       req_body_i,
  output logic                                req_credit_o,
  input  logic                                resp_credit_i,
  output logic                                resp_valid_o,
  output logic                                resp_cmd_o,
  output logic [mem_packet_pkg::ADDR_W-1:0]   resp_addr_o,
  output logic [mem_packet_pkg::TAG_W-1:0]    resp_tag_o,
  output logic [mem_packet_pkg::DATA_W-1:0]   resp_data_o,
  output logic                                mem_valid_o,
  output logic [mem_packet_pkg::ADDR_W-1:0]   mem_addr_o,
  output logic [mem_packet_pkg::DATA_W-1:0]   mem_wdata_o,
  output logic [mem_packet_pkg::STRB_W-1:0]   mem_wstrb_o,
  input  logic                                mem_ready_i,
  input  logic                                mem_rvalid_i,
  input  logic [mem_packet_pkg::DATA_W-1:0]   mem_rdata_i,
  input  logic                                mem_wtb_empty_i,
  output logic                                done_o
);

  // Queue head
  logic                              head_valid;
  logic                              head_cmd;
  logic [mem_packet_pkg::ADDR_W-1:0] head_addr;
  mem_packet_pkg::mem_req_body_u     head_body;
  logic                              head_pop;
  logic                              req_empty;

  // Response queue handshake
  logic resp_push;
  logic resp_almost_full;
  logic resp_empty;

  request_path i_request_path (
    .ap_clk (ap_clk), .areset_control (areset_control),
    .desc_valid_i (desc_valid_i), .desc_base_i (desc_base_i),
    .req_valid_i (req_valid_i), .req_cmd_i (req_cmd_i),
    .req_addr_i (req_addr_i), .req_body_i (req_body_i),
    .head_pop_i (head_pop), .req_credit_o (req_credit_o),
    .head_valid_o (head_valid), .head_cmd_o (head_cmd),
    .head_addr_o (head_addr), .head_body_o (head_body),
    .empty_o (req_empty)
  );

  cu_cache_control i_cu_cache_control (
    .ap_clk (ap_clk), .areset_control (areset_control),
    .head_valid_i (head_valid), .head_cmd_i (head_cmd),
    .head_addr_i (head_addr), .head_body_i (head_body),
    .resp_almost_full_i (resp_almost_full), .req_empty_i (req_empty),
    .resp_empty_i (resp_empty), .mem_ready_i (mem_ready_i),
    .mem_rvalid_i (mem_rvalid_i), .mem_wtb_empty_i (mem_wtb_empty_i),
    .head_pop_o (head_pop), .resp_push_o (resp_push),
    .mem_valid_o (mem_valid_o), .mem_addr_o (mem_addr_o),
    .mem_wdata_o (mem_wdata_o), .mem_wstrb_o (mem_wstrb_o),
    .done_o (done_o)
  );

  // Reply formed from the head still in the request queue
  response_path i_response_path (
    .ap_clk (ap_clk), .areset_control (areset_control),
    .push_i (resp_push), .cmd_i (head_cmd), .addr_i (head_addr),
    .body_i (head_body), .mem_rdata_i (mem_rdata_i),
    .resp_credit_i (resp_credit_i), .almost_full_o (resp_almost_full),
    .empty_o (resp_empty), .resp_valid_o (resp_valid_o),
    .resp_cmd_o (resp_cmd_o), .resp_addr_o (resp_addr_o),
    .resp_tag_o (resp_tag_o), .resp_data_o (resp_data_o)
  );

endmodule

//--- source/response_path.sv
// --------------------------------------------------------------------------
// Response path
// Formats replies, queues them and releases one per held credit
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module response_path (
  input  logic                                ap_clk,
  input  logic                                areset_control,
  input  logic                                push_i,
  input  logic                                cmd_i,
  input  logic [mem_packet_pkg::ADDR_W-1:0]   addr_i,
  input  mem_packet_pkg::mem_req_body_u       body_i,
  input  logic [mem_packet_pkg::DATA_W-1:0]   mem_rdata_i,
  input  logic                                resp_credit_i,
  output logic                                almost_full_o,
  output logic                                empty_o,
  output logic                                resp_valid_o,
  output logic                                resp_cmd_o,
  output logic [mem_packet_pkg::ADDR_W-1:0]   resp_addr_o,
  output logic [mem_packet_pkg::TAG_W-1:0]    resp_tag_o,
  output logic [mem_packet_pkg::DATA_W-1:0]   resp_data_o
);

  localparam int ENTRY_W = 1 + mem_packet_pkg::ADDR_W + mem_packet_pkg::TAG_W
                           + mem_packet_pkg::DATA_W;

  logic                                  is_read;
  logic [ENTRY_W-1:0]                    reply;
  logic [ENTRY_W-1:0]                    head;
  logic [cu_cache_cfg_pkg::CREDIT_W-1:0] credits;
  logic                                  pop;

  // Tag and data only on reads, zero on writes
  assign is_read = (cmd_i == mem_packet_pkg::CMD_READ);
  assign reply   = {cmd_i, addr_i,
                    is_read ? body_i.rd[mem_packet_pkg::TAG_LSB +: mem_packet_pkg::TAG_W] : '0,
                    is_read ? mem_rdata_i : '0};

  sync_fifo #(
    .WIDTH       (ENTRY_W),
    .DEPTH       (cu_cache_cfg_pkg::RESP_FIFO_DEPTH),
    .ALMOST_FULL (cu_cache_cfg_pkg::RESP_ALMOST_FULL)
  ) i_resp_fifo (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .push_i         (push_i),
    .din_i          (reply),
    .pop_i          (pop),
    .dout_o         (head),
    .empty_o        (empty_o),
    .almost_full_o  (almost_full_o)
  );

  // Pop only with a credit in hand
  assign pop = ~empty_o & (credits != '0);

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      credits      <= '0;
      resp_valid_o <= 1'b0;
    end else begin
      credits      <= credits + resp_credit_i - pop;
      resp_valid_o <= pop;
    end
  end

  // Output register
  always_ff @(posedge ap_clk) begin
    if (pop) begin
      {resp_cmd_o, resp_addr_o, resp_tag_o, resp_data_o} <= head;
    end
  end

endmodule

//--- source/cu_cache_control.sv
// --------------------------------------------------------------------------
// Command control
// Issues queued requests to the backend port, tracks writes against the
// backend write buffer and raises done once everything has drained
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module cu_cache_control (
  input  logic                                ap_clk,
  input  logic                                areset_control,
  input  logic                                head_valid_i,
  input  logic                                head_cmd_i,
  input  logic [mem_packet_pkg::ADDR_W-1:0]   head_addr_i,
  input  mem_packet_pkg::mem_req_body_u       head_body_i,
  input  logic                                resp_almost_full_i,
  input  logic                                req_empty_i,
  input  logic                                resp_empty_i,
  input  logic                                mem_ready_i,
  input  logic                                mem_rvalid_i,
  input  logic                                mem_wtb_empty_i,
  output logic                                head_pop_o,
  output logic                                resp_push_o,
  output logic                                mem_valid_o,
  output logic [mem_packet_pkg::ADDR_W-1:0]   mem_addr_o,
  output logic [mem_packet_pkg::DATA_W-1:0]   mem_wdata_o,
  output logic [mem_packet_pkg::STRB_W-1:0]   mem_wstrb_o,
  output logic                                done_o
);

  logic [cu_cache_cfg_pkg::STATE_W-1:0]  state;
  logic [cu_cache_cfg_pkg::STATE_W-1:0]  next_state;
  logic [cu_cache_cfg_pkg::CREDIT_W-1:0] wr_count;

  logic can_issue;
  logic wtbuf_full;
  logic read_cond;
  logic write_cond;
  logic write_issue;
  logic drained;
  logic [cu_cache_cfg_pkg::DONE_SYNC_STAGES-1:0] done_sync;

  // ------------------------------------------------------------------------
  // Issue conditions
  // ------------------------------------------------------------------------
  assign can_issue  = head_valid_i & mem_ready_i & ~resp_almost_full_i;
  // Too many writes while the buffer still holds data
  assign wtbuf_full = (wr_count >= cu_cache_cfg_pkg::WTBUF_DEPTH) & ~mem_wtb_empty_i;
  assign read_cond  = can_issue & (head_cmd_i == mem_packet_pkg::CMD_READ);
  assign write_cond = can_issue & (head_cmd_i == mem_packet_pkg::CMD_WRITE) & ~wtbuf_full;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      state <= cu_cache_cfg_pkg::ST_RESET;
    end else begin
      state <= next_state;
    end
  end

  // ------------------------------------------------------------------------
  // Next state
  // ------------------------------------------------------------------------
  always_comb begin
    next_state = state;
    case (state)
      cu_cache_cfg_pkg::ST_RESET: begin
        next_state = cu_cache_cfg_pkg::ST_READY;
      end
      cu_cache_cfg_pkg::ST_READY: begin
        // Reads take priority
        if (read_cond) begin
          next_state = cu_cache_cfg_pkg::ST_READ;
        end else if (write_cond) begin
          next_state = cu_cache_cfg_pkg::ST_WRITE;
        end
      end
      cu_cache_cfg_pkg::ST_READ: begin
        if (mem_rvalid_i) begin
          next_state = cu_cache_cfg_pkg::ST_READY;
        end
      end
      default: begin
        next_state = cu_cache_cfg_pkg::ST_READY;
      end
    endcase
  end

  // Port strobes from the current state
  always_comb begin
    mem_valid_o = 1'b0;
    head_pop_o  = 1'b0;
    resp_push_o = 1'b0;
    case (state)
      cu_cache_cfg_pkg::ST_READ: begin
        // Held until the read data returns
        mem_valid_o = ~mem_rvalid_i;
        head_pop_o  = mem_rvalid_i;
        resp_push_o = mem_rvalid_i;
      end
      cu_cache_cfg_pkg::ST_WRITE: begin
        // Single cycle, always accepted
        mem_valid_o = 1'b1;
        head_pop_o  = 1'b1;
        resp_push_o = 1'b1;
      end
      default: begin
        mem_valid_o = 1'b0;
      end
    endcase
  end

  // Backend fields from the queue head
  assign mem_addr_o  = head_addr_i;
  assign mem_wdata_o = head_body_i.wr[mem_packet_pkg::WDATA_LSB +: mem_packet_pkg::DATA_W];
  assign mem_wstrb_o = head_body_i.wr[mem_packet_pkg::WSTRB_LSB +: mem_packet_pkg::STRB_W]
                       & {mem_packet_pkg::STRB_W{head_cmd_i == mem_packet_pkg::CMD_WRITE}};

  // ------------------------------------------------------------------------
  // Write buffer counter and done
  // ------------------------------------------------------------------------
  assign write_issue = (state == cu_cache_cfg_pkg::ST_WRITE);

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_count <= '0;
    end else if (mem_wtb_empty_i) begin
      // Buffer drained, only this cycle's write remains
      wr_count <= {{(cu_cache_cfg_pkg::CREDIT_W-1){1'b0}}, write_issue};
    end else if (write_issue) begin
      wr_count <= wr_count + 1'b1;
    end
  end

  assign drained = req_empty_i & resp_empty_i & mem_wtb_empty_i & mem_ready_i
                   & (state == cu_cache_cfg_pkg::ST_READY);

  // Fixed two-stage latency to done_o
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      done_sync <= '0;
    end else begin
      done_sync <= {done_sync[cu_cache_cfg_pkg::DONE_SYNC_STAGES-2:0], drained};
    end
  end

  assign done_o = done_sync[cu_cache_cfg_pkg::DONE_SYNC_STAGES-1];

endmodule

//--- source/request_path.sv
// --------------------------------------------------------------------------
// Request path
// Holds the descriptor, registers requests twice adding the base address,
// queues them and returns one credit per pop
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module request_path (
  input  logic                                ap_clk,
  input  logic                                areset_control,
  input  logic                                desc_valid_i,
  input  logic [mem_packet_pkg::ADDR_W-1:0]   desc_base_i,
  input  logic                                req_valid_i,
  input  logic                                req_cmd_i,
  input  logic [mem_packet_pkg::ADDR_W-1:0]   req_addr_i,
  input  mem_packet_pkg::mem_req_body_u       req_body_i,
  input  logic                                head_pop_i,
  output logic                                req_credit_o,
  output logic                                head_valid_o,
  output logic                                head_cmd_o,
  output logic [mem_packet_pkg::ADDR_W-1:0]   head_addr_o,
  output mem_packet_pkg::mem_req_body_u       head_body_o,
  output logic                                empty_o
);

  localparam int ENTRY_W = 1 + mem_packet_pkg::ADDR_W + mem_packet_pkg::BODY_W;

  logic                              desc_held;
  logic [mem_packet_pkg::ADDR_W-1:0] desc_base;

  // Pipeline stages
  logic                              s1_valid;
  logic                              s1_cmd;
  logic [mem_packet_pkg::ADDR_W-1:0] s1_addr;
  mem_packet_pkg::mem_req_body_u     s1_body;
  logic                              s2_valid;
  logic [ENTRY_W-1:0]                s2_entry;
  logic [ENTRY_W-1:0]                head_entry;

  // ------------------------------------------------------------------------
  // Control registers
  // ------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      desc_held    <= 1'b0;
      s1_valid     <= 1'b0;
      s2_valid     <= 1'b0;
      req_credit_o <= 1'b0;
    end else begin
      // Descriptor stays valid until reset
      if (desc_valid_i) begin
        desc_held <= 1'b1;
      end
      s1_valid     <= req_valid_i;
      s2_valid     <= s1_valid;
      // One credit back per queue pop
      req_credit_o <= head_pop_i;
    end
  end

  // Payload registers
  always_ff @(posedge ap_clk) begin
    if (desc_valid_i) begin
      desc_base <= desc_base_i;
    end
    s1_cmd   <= req_cmd_i;
    s1_addr  <= req_addr_i;
    s1_body  <= req_body_i;
    // Base offset in the second stage
    s2_entry <= {s1_cmd, s1_addr + desc_base, s1_body};
  end

  // ------------------------------------------------------------------------
  // Request queue
  // ------------------------------------------------------------------------
  sync_fifo #(
    .WIDTH       (ENTRY_W),
    .DEPTH       (cu_cache_cfg_pkg::REQ_FIFO_DEPTH),
    .ALMOST_FULL (cu_cache_cfg_pkg::REQ_FIFO_DEPTH)
  ) i_req_fifo (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .push_i         (s2_valid),
    .din_i          (s2_entry),
    .pop_i          (head_pop_i),
    .dout_o         (head_entry),
    .empty_o        (empty_o),
    .almost_full_o  ()
  );

  // Head fields, gated by the descriptor
  assign {head_cmd_o, head_addr_o, head_body_o} = head_entry;
  assign head_valid_o = ~empty_o & desc_held;

endmodule

//--- source/sync_fifo.sv
// --------------------------------------------------------------------------
// Synchronous FIFO, first word falls through
// Head is visible without a pop, almost-full taken from the occupancy count
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module sync_fifo #(
  parameter int WIDTH       = 32,
  parameter int DEPTH       = 16,
  parameter int ALMOST_FULL = 14
) (
  input  logic             ap_clk,
  input  logic             areset_control,
  input  logic             push_i,
  input  logic [WIDTH-1:0] din_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] dout_o,
  output logic             empty_o,
  output logic             almost_full_o
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [CNT_W-1:0] AF_LEVEL = CNT_W'(ALMOST_FULL);

  // Storage, no reset
  logic [WIDTH-1:0] mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  always_ff @(posedge ap_clk) begin
    if (push_i) begin
      mem[wr_ptr] <= din_i;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_i) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head word straight from the array
  assign dout_o        = mem[rd_ptr];
  assign empty_o       = (count == '0);
  assign almost_full_o = (count >= AF_LEVEL);

endmodule

//--- source/mem_packet_pkg.sv
// --------------------------------------------------------------------------
// Memory packet format
// Field widths, command codes and the request body union
// --------------------------------------------------------------------------

package mem_packet_pkg;

  // Word address and data
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;
  localparam int STRB_W = 4;
  localparam int TAG_W  = 8;

  // One-bit command codes
  localparam logic CMD_READ  = 1'b0;
  localparam logic CMD_WRITE = 1'b1;

  // Body is strobes over data, or reserved bits over a tag
  localparam int BODY_W = STRB_W + DATA_W;
  localparam int RSVD_W = BODY_W - TAG_W;

  // Field positions inside each view
  localparam int WDATA_LSB = 0;
  localparam int WSTRB_LSB = DATA_W;
  localparam int TAG_LSB   = 0;

  // Write view  {wstrb, wdata}
  // Read view   {28 reserved bits, tag}
  typedef union packed {
    logic [BODY_W-1:0] wr;
    logic [BODY_W-1:0] rd;
  } mem_req_body_u;

endpackage

//--- source/cu_cache_cfg_pkg.sv
// --------------------------------------------------------------------------
// Front end configuration
// Queue depths, credit widths, write buffer limit and FSM state codes
// --------------------------------------------------------------------------

package cu_cache_cfg_pkg;

  // Request and response queue sizes
  localparam int REQ_FIFO_DEPTH   = 16;
  localparam int RESP_FIFO_DEPTH  = 16;
  // Fill level that stops new commands
  localparam int RESP_ALMOST_FULL = 14;

  // Credit counter and write counter width
  localparam int CREDIT_W = 5;

  // Writes allowed in flight while the backend buffer is not empty
  localparam logic [CREDIT_W-1:0] WTBUF_DEPTH = 5'd8;

  // Registers between the drain condition and done_o
  localparam int DONE_SYNC_STAGES = 2;

  // Command FSM encoding
  localparam int STATE_W = 2;
  localparam logic [STATE_W-1:0] ST_RESET = 2'd0;
  localparam logic [STATE_W-1:0] ST_READY = 2'd1;
  localparam logic [STATE_W-1:0] ST_READ  = 2'd2;
  localparam logic [STATE_W-1:0] ST_WRITE = 2'd3;

endpackage
